// File: verilog/video_timing_pkg.sv
// raster timing constants, region boundaries and position width for the test raster
`default_nettype none

package video_timing_pkg;

	localparam int pos_w = 12;                                     // counter and position width.

	localparam logic [pos_w-1:0] h_active = pos_w'(16);            // visible pixels per line.
	localparam logic [pos_w-1:0] h_front  = pos_w'(2);
	localparam logic [pos_w-1:0] h_pulse  = pos_w'(3);
	localparam logic [pos_w-1:0] h_back   = pos_w'(3);
	localparam logic [pos_w-1:0] h_line   = h_back + h_active + h_front + h_pulse;

	localparam logic [pos_w-1:0] v_active = pos_w'(8);             // visible lines per frame.
	localparam logic [pos_w-1:0] v_front  = pos_w'(1);
	localparam logic [pos_w-1:0] v_pulse  = pos_w'(2);
	localparam logic [pos_w-1:0] v_back   = pos_w'(1);
	localparam logic [pos_w-1:0] v_line   = v_back + v_active + v_front + v_pulse;

	// each line runs back porch, active, front porch and then sync
	localparam logic [pos_w-1:0] h_act_end    = h_back + h_active; // first clock after active.
	localparam logic [pos_w-1:0] v_act_end    = v_back + v_active;
	localparam logic [pos_w-1:0] h_sync_start = h_line - h_pulse;  // sync sits at the line end.
	localparam logic [pos_w-1:0] v_sync_start = v_line - v_pulse;

	localparam int pipe_depth = 3;                                 // counter to port latency.

endpackage

`default_nettype wire

// File: verilog/fb_pkg.sv
// frame-buffer geometry, pixel width and the host opcode, host state and arbiter owner enums
`default_nettype none

package fb_pkg;

	localparam int pix_w = 12;                                     // rgb444.

	// one word per visible pixel
	localparam int fb_depth = int'(video_timing_pkg::h_active) * int'(video_timing_pkg::v_active);
	localparam int addr_w   = $clog2(fb_depth);

	typedef enum logic [1:0] {
		op_write = 2'd0,                                           // store one pixel.
		op_read  = 2'd1,                                           // return one pixel.
		op_fill  = 2'd2                                            // paint the whole buffer.
	} opcode_e;

	typedef enum logic [1:0] {
		st_idle   = 2'd0,                                          // waiting for a command.
		st_access = 2'd1,                                          // single write or read pending.
		st_fill   = 2'd2,                                          // walking the buffer.
		st_resp   = 2'd3                                           // response held for the host.
	} host_state_e;

	typedef enum logic [1:0] {
		own_none = 2'd0,
		own_scan = 2'd1,
		own_host = 2'd2
	} owner_e;

endpackage

`default_nettype wire

// File: verilog/video_timing.sv
// raster counters, early fetch position and the three-stage sync, blank, enable and position outputs
`default_nettype none

module video_timing (
	input  wire logic                                 i_clock_out,
	input  wire logic                                 i_rst,
	output logic                                      o_fetch_valid,
	output logic [fb_pkg::addr_w-1:0]                 o_fetch_addr,
	output logic                                      o_hsync,
	output logic                                      o_vsync,
	output logic                                      o_hblank,
	output logic                                      o_vblank,
	output logic                                      o_data_enable,
	output logic [video_timing_pkg::pos_w-1:0]        o_pos_x,
	output logic [video_timing_pkg::pos_w-1:0]        o_pos_y
);

	logic [video_timing_pkg::pos_w-1:0] cnt_h;
	logic [video_timing_pkg::pos_w-1:0] cnt_v;
	logic                               h_act;
	logic                               v_act;
	logic [video_timing_pkg::pos_w-1:0] cur_x;
	logic [video_timing_pkg::pos_w-1:0] cur_y;
	logic [video_timing_pkg::pos_w-1:0] lin_addr;

	logic [video_timing_pkg::pipe_depth-1:0] hs_pipe;
	logic [video_timing_pkg::pipe_depth-1:0] vs_pipe;
	logic [video_timing_pkg::pipe_depth-1:0] hb_pipe;
	logic [video_timing_pkg::pipe_depth-1:0] vb_pipe;
	logic [video_timing_pkg::pipe_depth-1:0] de_pipe;
	logic [video_timing_pkg::pos_w-1:0]      px_pipe [video_timing_pkg::pipe_depth];
	logic [video_timing_pkg::pos_w-1:0]      py_pipe [video_timing_pkg::pipe_depth];

	always_ff @(posedge i_clock_out) begin
		if (i_rst) begin
			cnt_h <= '0;
			cnt_v <= '0;
		end else if (cnt_h == video_timing_pkg::h_line - 1'b1) begin
			cnt_h <= '0;
			if (cnt_v == video_timing_pkg::v_line - 1'b1)
				cnt_v <= '0;
			else
				cnt_v <= cnt_v + 1'b1;
		end else begin
			cnt_h <= cnt_h + 1'b1;
		end
	end

	assign h_act = (cnt_h >= video_timing_pkg::h_back) && (cnt_h < video_timing_pkg::h_act_end);
	assign v_act = (cnt_v >= video_timing_pkg::v_back) && (cnt_v < video_timing_pkg::v_act_end);
	assign cur_x = cnt_h - video_timing_pkg::h_back;               // wraps outside active.
	assign cur_y = cnt_v - video_timing_pkg::v_back;

	// fetch side sees the position pipe_depth cycles ahead of the ports
	assign lin_addr      = cur_y * video_timing_pkg::h_active + cur_x;
	assign o_fetch_addr  = lin_addr[fb_pkg::addr_w-1:0];
	assign o_fetch_valid = h_act & v_act;

	always_ff @(posedge i_clock_out) begin
		if (i_rst) begin
			hs_pipe <= '0;                                         // positive sync, idle low.
			vs_pipe <= '0;
			hb_pipe <= '0;
			vb_pipe <= '0;
			de_pipe <= '0;
			for (int i = 0; i < video_timing_pkg::pipe_depth; i++) begin
				px_pipe[i] <= '0;
				py_pipe[i] <= '0;
			end
		end else begin
			hs_pipe <= {hs_pipe[video_timing_pkg::pipe_depth-2:0],
				(cnt_h >= video_timing_pkg::h_sync_start)};
			vs_pipe <= {vs_pipe[video_timing_pkg::pipe_depth-2:0],
				(cnt_v >= video_timing_pkg::v_sync_start)};
			hb_pipe <= {hb_pipe[video_timing_pkg::pipe_depth-2:0], h_act};
			vb_pipe <= {vb_pipe[video_timing_pkg::pipe_depth-2:0], v_act};
			de_pipe <= {de_pipe[video_timing_pkg::pipe_depth-2:0], h_act & v_act};
			px_pipe[0] <= cur_x;
			py_pipe[0] <= cur_y;
			for (int i = 1; i < video_timing_pkg::pipe_depth; i++) begin
				px_pipe[i] <= px_pipe[i-1];
				py_pipe[i] <= py_pipe[i-1];
			end
		end
	end

	assign o_hsync       = hs_pipe[video_timing_pkg::pipe_depth-1];
	assign o_vsync       = vs_pipe[video_timing_pkg::pipe_depth-1];
	assign o_hblank      = hb_pipe[video_timing_pkg::pipe_depth-1]; // high while active.
	assign o_vblank      = vb_pipe[video_timing_pkg::pipe_depth-1];
	assign o_data_enable = de_pipe[video_timing_pkg::pipe_depth-1];
	assign o_pos_x       = px_pipe[video_timing_pkg::pipe_depth-1];
	assign o_pos_y       = py_pipe[video_timing_pkg::pipe_depth-1];

endmodule

`default_nettype wire

// File: verilog/scanout_fetch.sv
// scanout fetch unit that reads pixels at the early position and aligns them with the timing outputs
`default_nettype none

module scanout_fetch (
	input  wire logic                      i_clock_out,
	input  wire logic                      i_rst,
	input  wire logic                      i_fetch_valid,
	input  wire logic [fb_pkg::addr_w-1:0] i_fetch_addr,
	input  wire logic                      i_scan_gnt,
	input  wire logic [fb_pkg::pix_w-1:0]  i_rd_data,
	output logic                           o_scan_req,
	output logic [fb_pkg::addr_w-1:0]      o_scan_addr,
	output logic [fb_pkg::pix_w-1:0]       o_rgb
);

	logic                     rd_pend;                             // read issued last cycle.
	logic                     cap_vld;
	logic [fb_pkg::pix_w-1:0] cap_pix;

	// request in the counter cycle, one word per active position
	assign o_scan_req  = i_fetch_valid;
	assign o_scan_addr = i_fetch_addr;

	always_ff @(posedge i_clock_out) begin
		if (i_rst) begin
			rd_pend <= 1'b0;
			cap_vld <= 1'b0;
			o_rgb   <= '0;
		end else begin
			rd_pend <= o_scan_req & i_scan_gnt;
			cap_vld <= rd_pend;                                    // second alignment stage.
			if (cap_vld)
				o_rgb <= cap_pix;
			else
				o_rgb <= '0;                                       // black outside active.
		end
	end

	// ram output is only meaningful the cycle after a granted read
	always_ff @(posedge i_clock_out) begin
		if (rd_pend)
			cap_pix <= i_rd_data;
	end

endmodule

`default_nettype wire

// File: verilog/host_port.sv
// host command FSM that turns write, read and fill commands into frame-buffer accesses and responses
`default_nettype none

module host_port (
	input  wire logic                      i_clock_out,
	input  wire logic                      i_rst,
	input  wire logic                      i_cmd_valid,
	input  wire fb_pkg::opcode_e           i_cmd_op,
	input  wire logic [fb_pkg::addr_w-1:0] i_cmd_addr,
	input  wire logic [fb_pkg::pix_w-1:0]  i_cmd_data,
	input  wire logic                      i_rsp_ready,
	input  wire logic                      i_host_gnt,
	input  wire logic [fb_pkg::pix_w-1:0]  i_rd_data,
	output logic                           o_cmd_ready,
	output logic                           o_rsp_valid,
	output logic [fb_pkg::pix_w-1:0]       o_rsp_data,
	output logic                           o_host_req,
	output logic [fb_pkg::addr_w-1:0]      o_host_addr,
	output logic                           o_host_we,
	output logic [fb_pkg::pix_w-1:0]       o_host_wdata
);

	localparam logic [fb_pkg::addr_w-1:0] last_addr = fb_pkg::addr_w'(fb_pkg::fb_depth - 1);

	fb_pkg::host_state_e       state;
	fb_pkg::opcode_e           cmd_op;
	logic [fb_pkg::addr_w-1:0] cmd_addr;
	logic [fb_pkg::pix_w-1:0]  cmd_data;
	logic [fb_pkg::addr_w-1:0] fill_addr;
	logic                      rd_wait;                            // read data lands next cycle.

	assign o_cmd_ready  = (state == fb_pkg::st_idle);
	assign o_host_req   = (state == fb_pkg::st_access) || (state == fb_pkg::st_fill);
	assign o_host_addr  = (state == fb_pkg::st_fill) ? fill_addr : cmd_addr;
	assign o_host_we    = (state == fb_pkg::st_fill) || (cmd_op == fb_pkg::op_write);
	assign o_host_wdata = cmd_data;                                // fill colour or write pixel.

	always_ff @(posedge i_clock_out) begin
		if (o_cmd_ready && i_cmd_valid) begin
			cmd_op   <= i_cmd_op;
			cmd_addr <= i_cmd_addr;
			cmd_data <= i_cmd_data;
		end
	end

	always_ff @(posedge i_clock_out) begin
		if (i_rst) begin
			state       <= fb_pkg::st_idle;
			fill_addr   <= '0;
			rd_wait     <= 1'b0;
			o_rsp_valid <= 1'b0;
			o_rsp_data  <= '0;
		end else begin
			unique case (state)
				fb_pkg::st_idle: begin
					if (i_cmd_valid) begin
						fill_addr <= '0;
						if (i_cmd_op == fb_pkg::op_fill)
							state <= fb_pkg::st_fill;
						else
							state <= fb_pkg::st_access;    // unknown opcodes act as reads.
					end
				end
				fb_pkg::st_access: begin
					if (i_host_gnt) begin
						rd_wait     <= (cmd_op != fb_pkg::op_write);
						o_rsp_valid <= (cmd_op == fb_pkg::op_write);
						o_rsp_data  <= '0;
						state       <= fb_pkg::st_resp;
					end
				end
				fb_pkg::st_fill: begin
					if (i_host_gnt) begin
						if (fill_addr == last_addr) begin
							o_rsp_valid <= 1'b1;
							o_rsp_data  <= '0;
							state       <= fb_pkg::st_resp;
						end else begin
							fill_addr <= fill_addr + 1'b1;
						end
					end
				end
				fb_pkg::st_resp: begin
					if (rd_wait) begin
						rd_wait     <= 1'b0;
						o_rsp_valid <= 1'b1;
						o_rsp_data  <= i_rd_data;
					end else if (i_rsp_ready) begin
						o_rsp_valid <= 1'b0;
						state       <= fb_pkg::st_idle;
					end
				end
				default: state <= fb_pkg::st_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/fb_arbiter.sv
// fixed-priority arbiter for the single frame-buffer port, scanout ahead of host
`default_nettype none

module fb_arbiter (
	input  wire logic                      i_clock_out,
	input  wire logic                      i_rst,
	input  wire logic                      i_scan_req,
	input  wire logic [fb_pkg::addr_w-1:0] i_scan_addr,
	input  wire logic                      i_host_req,
	input  wire logic [fb_pkg::addr_w-1:0] i_host_addr,
	input  wire logic                      i_host_we,
	input  wire logic [fb_pkg::pix_w-1:0]  i_host_wdata,
	output logic                           o_scan_gnt,
	output logic                           o_host_gnt,
	output logic [fb_pkg::addr_w-1:0]      o_mem_addr,
	output logic                           o_mem_we,
	output logic [fb_pkg::pix_w-1:0]       o_mem_wdata
);

	fb_pkg::owner_e owner_now;
	fb_pkg::owner_e owner_q;                                       // owner of the returning read.

	always_comb begin
		if (i_scan_req)
			owner_now = fb_pkg::own_scan;
		else if (i_host_req)
			owner_now = fb_pkg::own_host;
		else
			owner_now = fb_pkg::own_none;
	end

	assign o_scan_gnt  = (owner_now == fb_pkg::own_scan);
	assign o_host_gnt  = (owner_now == fb_pkg::own_host);
	assign o_mem_we    = o_host_gnt & i_host_we;                   // scanout never writes.
	assign o_mem_wdata = i_host_wdata;

	always_comb begin
		unique case (owner_now)
			fb_pkg::own_scan: o_mem_addr = i_scan_addr;
			fb_pkg::own_host: o_mem_addr = i_host_addr;
			default:          o_mem_addr = (owner_q == fb_pkg::own_host) ? i_host_addr
			                                                             : i_scan_addr;
		endcase
	end

	// idle cycles keep the last owner's address on the bus
	always_ff @(posedge i_clock_out) begin
		if (i_rst)
			owner_q <= fb_pkg::own_none;
		else
			owner_q <= owner_now;
	end

endmodule

`default_nettype wire

// File: verilog/fb_ram.sv
// single-port frame-buffer memory with synchronous write and registered read
`default_nettype none

module fb_ram (
	input  wire logic                      i_clock_out,
	input  wire logic [fb_pkg::addr_w-1:0] i_addr,
	input  wire logic                      i_we,
	input  wire logic [fb_pkg::pix_w-1:0]  i_wdata,
	output logic [fb_pkg::pix_w-1:0]       o_rd_data
);

	logic [fb_pkg::pix_w-1:0] mem [fb_pkg::fb_depth];              // one word per pixel.

	always_ff @(posedge i_clock_out) begin
		if (i_we)
			mem[i_addr] <= i_wdata;
	end

	// read returns the old word on a same-cycle write
	always_ff @(posedge i_clock_out) begin
		o_rd_data <= mem[i_addr];
	end

endmodule

`default_nettype wire

// File: verilog/video_top.sv
// video subsystem top with timing generator, scanout fetch, host port, arbiter and frame buffer
`default_nettype none

module video_top (
	input  wire logic                                 i_clock_out,
	input  wire logic                                 i_rst,
	input  wire logic                                 i_cmd_valid,
	output logic                                      o_cmd_ready,
	input  wire fb_pkg::opcode_e                      i_cmd_op,
	input  wire logic [fb_pkg::addr_w-1:0]            i_cmd_addr,
	input  wire logic [fb_pkg::pix_w-1:0]             i_cmd_data,
	output logic                                      o_rsp_valid,
	output logic [fb_pkg::pix_w-1:0]                  o_rsp_data,
	input  wire logic                                 i_rsp_ready,
	output logic                                      o_hsync,
	output logic                                      o_vsync,
	output logic                                      o_hblank,
	output logic                                      o_vblank,
	output logic                                      o_data_enable,
	output logic [video_timing_pkg::pos_w-1:0]        o_pos_x,
	output logic [video_timing_pkg::pos_w-1:0]        o_pos_y,
	output logic [fb_pkg::pix_w-1:0]                  o_rgb
);

	wire                      fetch_valid;
	wire [fb_pkg::addr_w-1:0] fetch_addr;
	wire                      scan_req;
	wire                      scan_gnt;
	wire [fb_pkg::addr_w-1:0] scan_addr;
	wire                      host_req;
	wire                      host_gnt;
	wire [fb_pkg::addr_w-1:0] host_addr;
	wire                      host_we;
	wire [fb_pkg::pix_w-1:0]  host_wdata;
	wire [fb_pkg::addr_w-1:0] mem_addr;
	wire                      mem_we;
	wire [fb_pkg::pix_w-1:0]  mem_wdata;
	wire [fb_pkg::pix_w-1:0]  rd_data;                             // shared by both readers.

	video_timing timing0 (
		.i_clock_out(i_clock_out), .i_rst(i_rst),
		.o_fetch_valid(fetch_valid), .o_fetch_addr(fetch_addr),
		.o_hsync(o_hsync), .o_vsync(o_vsync), .o_hblank(o_hblank), .o_vblank(o_vblank),
		.o_data_enable(o_data_enable), .o_pos_x(o_pos_x), .o_pos_y(o_pos_y)
	);

	scanout_fetch fetch0 (
		.i_clock_out(i_clock_out), .i_rst(i_rst),
		.i_fetch_valid(fetch_valid), .i_fetch_addr(fetch_addr),
		.i_scan_gnt(scan_gnt), .i_rd_data(rd_data),
		.o_scan_req(scan_req), .o_scan_addr(scan_addr), .o_rgb(o_rgb)
	);

	host_port host0 (
		.i_clock_out(i_clock_out), .i_rst(i_rst),
		.i_cmd_valid(i_cmd_valid), .i_cmd_op(i_cmd_op), .i_cmd_addr(i_cmd_addr),
		.i_cmd_data(i_cmd_data), .i_rsp_ready(i_rsp_ready),
		.i_host_gnt(host_gnt), .i_rd_data(rd_data),
		.o_cmd_ready(o_cmd_ready), .o_rsp_valid(o_rsp_valid), .o_rsp_data(o_rsp_data),
		.o_host_req(host_req), .o_host_addr(host_addr), .o_host_we(host_we),
		.o_host_wdata(host_wdata)
	);

	fb_arbiter arb0 (
		.i_clock_out(i_clock_out), .i_rst(i_rst),
		.i_scan_req(scan_req), .i_scan_addr(scan_addr),
		.i_host_req(host_req), .i_host_addr(host_addr),
		.i_host_we(host_we), .i_host_wdata(host_wdata),
		.o_scan_gnt(scan_gnt), .o_host_gnt(host_gnt),
		.o_mem_addr(mem_addr), .o_mem_we(mem_we), .o_mem_wdata(mem_wdata)
	);

	fb_ram ram0 (
		.i_clock_out(i_clock_out), .i_addr(mem_addr), .i_we(mem_we),
		.i_wdata(mem_wdata), .o_rd_data(rd_data)
	);

endmodule

`default_nettype wire

// File: verification/tb_video_top.sv
// testbench with command table, frame-buffer model, raster, scanout and back-pressure checks
`default_nettype none

module tb_video_top;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int pos_w        = video_timing_pkg::pos_w;
	localparam int pix_w        = fb_pkg::pix_w;
	localparam int addr_w       = fb_pkg::addr_w;
	localparam int fb_depth     = fb_pkg::fb_depth;
	localparam int h_line       = int'(video_timing_pkg::h_line);
	localparam int v_line       = int'(video_timing_pkg::v_line);
	localparam int h_back       = int'(video_timing_pkg::h_back);
	localparam int v_back       = int'(video_timing_pkg::v_back);
	localparam int h_active     = int'(video_timing_pkg::h_active);
	localparam int v_active     = int'(video_timing_pkg::v_active);
	localparam int h_pulse      = int'(video_timing_pkg::h_pulse);
	localparam int v_pulse      = int'(video_timing_pkg::v_pulse);
	localparam int frame_cycles = h_line * v_line;
	localparam int n_cmds       = 26;
	localparam int cycle_limit  = n_cmds * 4 * fb_depth + 12 * frame_cycles; // fill fits a frame.

	typedef struct packed {
		fb_pkg::opcode_e   op;
		logic [addr_w-1:0] addr;
		logic [pix_w-1:0]  data;
		logic [pix_w-1:0]  rsp;                                    // expected response data.
		logic [3:0]        hold;                                   // cycles with rsp ready low.
		logic              frame;                                  // check a frame afterwards.
	} cmd_t;

	logic               i_clock_out;
	logic               i_rst;
	logic               i_cmd_valid;
	logic               o_cmd_ready;
	fb_pkg::opcode_e    i_cmd_op;
	logic [addr_w-1:0]  i_cmd_addr;
	logic [pix_w-1:0]   i_cmd_data;
	logic               o_rsp_valid;
	logic [pix_w-1:0]   o_rsp_data;
	logic               i_rsp_ready;
	logic               o_hsync;
	logic               o_vsync;
	logic               o_hblank;
	logic               o_vblank;
	logic               o_data_enable;
	logic [pos_w-1:0]   o_pos_x;
	logic [pos_w-1:0]   o_pos_y;
	logic [pix_w-1:0]   o_rgb;

	cmd_t               cmd_tbl [n_cmds];
	int                 n_used;
	logic [pix_w-1:0]   table_mem [fb_depth];                      // model while building the table.
	logic [pix_w-1:0]   fb_model [fb_depth];                       // buffer as the DUT should hold it.
	logic [31:0]        lfsr_state;
	int                 cycle_cnt = 0;

	video_top dut0 (.*);

	initial begin
		i_clock_out = 1'b0;
		forever #20 i_clock_out = ~i_clock_out;
	end

	always @(posedge i_clock_out)
		cycle_cnt <= cycle_cnt + 1;

	initial begin
		wait (cycle_cnt >= cycle_limit);
		fail_run($sformatf("timeout after %0d cycles, a command or frame never finished", cycle_cnt));
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_pixel(input string name, input logic [pix_w-1:0] exp,
			input logic [pix_w-1:0] act);
		if (act !== exp)
			fail_run($sformatf("Mismatch at %0t ns: %s expected %h got %h", $time, name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("Mismatch at %0t ns: %s expected %b got %b", $time, name, exp, act));
	endtask

	task automatic check_pos(input string name, input logic [pos_w-1:0] exp,
			input logic [pos_w-1:0] act);
		if (act !== exp)
			fail_run($sformatf("Mismatch at %0t ns: %s expected %0d got %0d", $time, name, exp, act));
	endtask

	// galois lfsr stepped once for every bit taken
	function automatic logic [31:0] draw_bits(input int nbits);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < nbits; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
		end
		return v;
	endfunction

	task automatic add_cmd(input fb_pkg::opcode_e op, input logic [addr_w-1:0] addr,
			input logic [pix_w-1:0] data, input int hold, input logic frame);
		cmd_t c;
		c.op    = op;
		c.addr  = addr;
		c.data  = data;
		c.hold  = 4'(hold);
		c.frame = frame;
		case (op)
			fb_pkg::op_write: begin
				c.rsp           = '0;
				table_mem[addr] = data;
			end
			fb_pkg::op_fill: begin
				c.rsp = '0;
				for (int i = 0; i < fb_depth; i++)
					table_mem[i] = data;
			end
			default: c.rsp = table_mem[addr];                      // read returns the last write.
		endcase
		cmd_tbl[n_used] = c;
		n_used++;
	endtask

	task automatic build_table();
		logic [addr_w-1:0] wr_addr [8];
		n_used = 0;
		add_cmd(fb_pkg::op_fill, '0, pix_w'(draw_bits(pix_w)), 0, 1'b1);
		for (int i = 0; i < 8; i++) begin
			wr_addr[i] = addr_w'(draw_bits(addr_w));
			add_cmd(fb_pkg::op_write, wr_addr[i], pix_w'(draw_bits(pix_w)), (i == 2) ? 5 : 0, 1'b0);
		end
		for (int i = 0; i < 8; i++)
			add_cmd(fb_pkg::op_read, wr_addr[i], '0, (i == 3) ? 6 : 0, i == 7);
		add_cmd(fb_pkg::op_write, wr_addr[0], pix_w'(draw_bits(pix_w)), 0, 1'b0);
		add_cmd(fb_pkg::op_read, wr_addr[0], '0, 4, 1'b0);
		add_cmd(fb_pkg::op_fill, '0, pix_w'(draw_bits(pix_w)), 3, 1'b1);
		for (int i = 0; i < 6; i++)
			add_cmd(fb_pkg::op_read, addr_w'(draw_bits(addr_w)), '0, (i == 1) ? 2 : 0, 1'b0);
	endtask

	task automatic check_idle_outputs();
		check_flag("o_data_enable", 1'b0, o_data_enable);
		check_flag("o_rsp_valid", 1'b0, o_rsp_valid);
		check_flag("o_cmd_ready", 1'b1, o_cmd_ready);
		check_flag("o_hsync", 1'b0, o_hsync);
		check_flag("o_vsync", 1'b0, o_vsync);
		check_flag("o_hblank", 1'b0, o_hblank);
		check_flag("o_vblank", 1'b0, o_vblank);
	endtask

	task automatic run_command(input cmd_t c);
		logic [pix_w-1:0] held;
		@(posedge i_clock_out);
		#2;
		i_cmd_valid = 1'b1;
		i_cmd_op    = c.op;
		i_cmd_addr  = c.addr;
		i_cmd_data  = c.data;
		i_rsp_ready = (c.hold == 0);
		@(negedge i_clock_out);
		check_flag("o_cmd_ready", 1'b1, o_cmd_ready);
		@(posedge i_clock_out);
		#2;
		i_cmd_valid = 1'b0;
		@(negedge i_clock_out);
		while (!o_rsp_valid) begin                                 // latency depends on scanout.
			check_flag("o_cmd_ready", 1'b0, o_cmd_ready);
			@(negedge i_clock_out);
		end
		check_pixel("o_rsp_data", c.rsp, o_rsp_data);
		held = o_rsp_data;
		repeat (c.hold) begin
			@(negedge i_clock_out);
			check_flag("o_rsp_valid", 1'b1, o_rsp_valid);
			check_pixel("o_rsp_data", held, o_rsp_data);
			check_flag("o_cmd_ready", 1'b0, o_cmd_ready);
		end
		if (c.hold != 0) begin
			@(posedge i_clock_out);
			#2;
			i_rsp_ready = 1'b1;
			@(negedge i_clock_out);
			check_flag("o_rsp_valid", 1'b1, o_rsp_valid);
		end
		@(negedge i_clock_out);
		check_flag("o_rsp_valid", 1'b0, o_rsp_valid);
		check_flag("o_cmd_ready", 1'b1, o_cmd_ready);
		if (c.op == fb_pkg::op_write) begin
			fb_model[c.addr] = c.data;
		end else if (c.op == fb_pkg::op_fill) begin
			for (int i = 0; i < fb_depth; i++)
				fb_model[i] = c.data;
		end
	endtask

	// one whole frame from the clock where vsync falls
	task automatic check_frame();
		logic vs_prev;
		logic exp_ha;
		logic exp_va;
		int   h;
		int   v;
		int   de_cnt;
		vs_prev = 1'b0;
		de_cnt  = 0;
		@(negedge i_clock_out);
		while (!(vs_prev && !o_vsync)) begin
			vs_prev = o_vsync;
			@(negedge i_clock_out);
		end
		for (int c = 0; c < frame_cycles; c++) begin
			if (c != 0)
				@(negedge i_clock_out);
			h      = c % h_line;
			v      = c / h_line;
			exp_ha = (h >= h_back) && (h < h_back + h_active); // back porch comes first.
			exp_va = (v >= v_back) && (v < v_back + v_active);
			check_flag("o_hsync", h >= h_line - h_pulse, o_hsync);
			check_flag("o_vsync", v >= v_line - v_pulse, o_vsync);
			check_flag("o_hblank", exp_ha, o_hblank);
			check_flag("o_vblank", exp_va, o_vblank);
			check_flag("o_data_enable", exp_ha && exp_va, o_data_enable);
			if (exp_ha && exp_va) begin
				check_pos("o_pos_x", pos_w'(h - h_back), o_pos_x);
				check_pos("o_pos_y", pos_w'(v - v_back), o_pos_y);
				check_pixel("o_rgb", fb_model[(v - v_back) * h_active + (h - h_back)], o_rgb);
			end else begin
				check_pixel("o_rgb", '0, o_rgb);
			end
			if (o_data_enable)
				de_cnt++;
		end
		check_pos("enabled cycles in frame", pos_w'(h_active * v_active), pos_w'(de_cnt));
	endtask

	initial begin
		i_rst       = 1'b1;
		i_cmd_valid = 1'b0;
		i_cmd_op    = fb_pkg::op_write;
		i_cmd_addr  = '0;
		i_cmd_data  = '0;
		i_rsp_ready = 1'b1;
		lfsr_state  = 32'h7e8e;
		build_table();
		@(posedge i_clock_out);                                    // first reset edge.
		repeat (15) begin
			@(negedge i_clock_out);
			check_idle_outputs();
			@(posedge i_clock_out);
		end
		#2;
		i_rst = 1'b0;
		@(negedge i_clock_out);
		check_idle_outputs();
		for (int k = 0; k < n_used; k++) begin
			run_command(cmd_tbl[k]);
			if (cmd_tbl[k].frame)
				check_frame();
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
verilog/video_timing_pkg.sv
verilog/fb_pkg.sv
verilog/video_timing.sv
verilog/scanout_fetch.sv
verilog/host_port.sv
verilog/fb_arbiter.sv
verilog/fb_ram.sv
verilog/video_top.sv
verification/tb_video_top.sv

// File: Makefile
BUILD := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f filelist.f --top-module tb_video_top \
		-Mdir $(BUILD) -o sim_video

run: compile
	./$(BUILD)/sim_video | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf $(BUILD) sim.log
